//--- src.f
+incdir+source
source/alu_contr_pkg.sv
source/alu_instr_stage.sv
source/alu_shift_link.sv
source/alu_carry_status.sv
source/alu_contr.sv
dv/alu_contr_assert.sv
dv/alu_contr_tb.sv

//--- Bender.yml
package:
  name: alu_contr

sources:
  - include_dirs:
      - source
    files:
      - source/alu_contr_pkg.sv
      - source/alu_instr_stage.sv
      - source/alu_shift_link.sv
      - source/alu_carry_status.sv
      - source/alu_contr.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/alu_contr_assert.sv
      - dv/alu_contr_tb.sv

//--- dv/alu_contr_tb.sv
// Testbench for the ALU controller
// Clock, reset, decode sweep, mode substitution and random linkage stimulus
// Per-test summary lines and a closing count

`timescale 1ns/1ps
`include "alu_contr_params.svh"

module alu_contr_tb;

  logic                        aluclk;
  logic                        arst_n;
  logic [`ALU_INSTR_W-1:0]     csalui;
  logic [`ALU_MODE_W-1:0]      csalum;
  logic [`ALU_SEL_W-1:0]       csmis, cssst, cscinsel, cd_10_9;
  logic                        ld_irv, up_n, lcz_n, ldgpr_n, xfetch_n;
  alu_contr_pkg::alu_data_t    data;
  alu_contr_pkg::alu_strobe_t  strobes;
  logic                        mi, rri, qli, rli, alud2_n, bdest, ci, gprli;
  logic [1:0]                  qsel;
  logic [`ALU_SEL_W-1:0]       csts;
  logic [`GPRC_W-1:0]          gprc;
  int                          mismatches = 0;
  int                          test_errs = 0;
  int                          tests = 0;
  logic                        exp_bdest;

  alu_contr UUT (.*);

  always #10 aluclk = ~aluclk;  // 20 ns period

  task automatic check_val(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
      mismatches++;
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("test %s done: %0d mismatches", name, test_errs);
    tests++;
    test_errs = 0;
  endtask

  // Datapath bits, flags and selects that the current test leaves free
  task automatic drive_random();
    data     = alu_contr_pkg::alu_data_t'(8'($urandom));
    up_n     = 1'($urandom);
    lcz_n    = 1'($urandom);
    ldgpr_n  = 1'($urandom);
    xfetch_n = 1'($urandom);
    cd_10_9  = 2'($urandom);
    ld_irv   = 1'($urandom);
    cssst    = 2'($urandom);
  endtask

  // Strobes must reach the decode of the instruction held on csalui
  task automatic wait_for_strobes(input logic [7:0] exp, input int limit);
    int n;
    n = 0;
    while (strobes != exp && n < limit) begin
      @(negedge aluclk);
      n++;
    end
    if (strobes != exp) begin
      $display("timeout: strobes never reached %0h after reset release", exp);
      $display(">>> FAIL");
      $finish;
    end
  endtask

  initial begin
    void'($urandom(32'h3af4db1c));
    aluclk   = 1'b0;
    arst_n   = 1'b0;
    csalui   = 9'b000_101_101;  // DA source, NOTRS function
    csalum   = alu_contr_pkg::MODE_NORMAL;
    csmis    = '0;
    cssst    = '0;
    cscinsel = '0;
    cd_10_9  = '0;
    ld_irv   = 1'b0;
    data     = '0;
    up_n     = 1'b1;
    lcz_n    = 1'b1;
    ldgpr_n  = 1'b1;
    xfetch_n = 1'b1;

    repeat (2) @(posedge aluclk);
    @(negedge aluclk);
    check_val("reset", 0, {strobes, bdest, ci});
    arst_n = 1'b1;
    wait_for_strobes(8'b0110_0110, 4);  // rd, sa, fsel, log
    finish_test("reset");

    for (int i = 0; i < 64; i++) begin
      drive_random();
      csalui = {3'($urandom), 6'(i)};
      @(negedge aluclk);
      check_val("decode", i[4], strobes.alui4);
    end
    finish_test("decode");

    for (int i = 0; i < 32; i++) begin
      drive_random();
      csalum = i[0] ? alu_contr_pkg::MODE_GPR_FUNC : alu_contr_pkg::MODE_GPR_SRC;
      csalui = 9'($urandom);
      @(negedge aluclk);
    end
    for (int i = 0; i < 32; i++) begin
      drive_random();
      csalum    = alu_contr_pkg::MODE_MIC;
      exp_bdest = ~up_n | ~lcz_n;
      @(negedge aluclk);
      check_val("mode_mic", exp_bdest, bdest);
    end
    finish_test("modes");

    csalum = alu_contr_pkg::MODE_NORMAL;
    for (int sel = 0; sel < 4; sel++) begin
      csmis = 2'(sel);
      for (int i = 0; i < 16; i++) begin
        drive_random();
        csalui = 9'($urandom);
        @(negedge aluclk);
      end
    end
    finish_test("shift_link");

    for (int sel = 0; sel < 4; sel++) begin
      cscinsel = 2'(sel);
      for (int i = 0; i < 16; i++) begin
        drive_random();
        csalum = 2'($urandom);
        csalui = 9'($urandom);
        @(negedge aluclk);
        if (sel < 2) check_val("carry_in", sel, ci);
      end
    end
    finish_test("carry_status");

    $display("tests %0d, mismatches %0d, assertion failures %0d",
             tests, mismatches, UUT.u_assert.fail_cnt);
    if (mismatches == 0 && UUT.u_assert.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- dv/alu_contr_assert.sv
// Concurrent assertions for the ALU controller
// Reference decode of strobes, control state, shift linkage, carry and status codes
// Bound into alu_contr at the end of this file

`timescale 1ns/1ps
`include "alu_contr_params.svh"

module alu_contr_assert (
  input logic                       aluclk,
  input logic                       arst_n,
  input logic [`ALU_INSTR_W-1:0]    csalui,
  input logic [`ALU_MODE_W-1:0]     csalum,
  input logic [`ALU_SEL_W-1:0]      csmis,
  input logic [`ALU_SEL_W-1:0]      cssst,
  input logic [`ALU_SEL_W-1:0]      cscinsel,
  input logic [`ALU_SEL_W-1:0]      cd_10_9,
  input logic                       ld_irv,
  input alu_contr_pkg::alu_data_t   data,
  input logic                       up_n,
  input logic                       lcz_n,
  input logic                       ldgpr_n,
  input logic                       xfetch_n,
  input alu_contr_pkg::alu_strobe_t strobes,
  input alu_contr_pkg::alu_state_t  state,
  input logic                       mi,
  input logic                       rri,
  input logic                       qli,
  input logic                       rli,
  input logic [1:0]                 qsel,
  input logic                       alud2_n,
  input logic                       bdest,
  input logic                       ci,
  input logic                       gprli,
  input logic [`ALU_SEL_W-1:0]      csts,
  input logic [`GPRC_W-1:0]         gprc
);

  logic [2:0]                 eff_src;
  logic [2:0]                 eff_func;
  logic [2:0]                 eff_dst;   // Bits 8:6 after substitution
  logic [1:0]                 cd_ref;    // Expected CPU-data latch
  logic [3:0]                 rri_opts;
  logic [3:0]                 qli_opts;
  logic [3:0]                 ci_opts;
  logic                       low_fq;
  alu_contr_pkg::alu_strobe_t exp_strb;
  int                         fail_cnt = 0;

  task automatic note_failure(input string what);
    fail_cnt++;
    $error("%s", what);
  endtask

  always_comb begin
    eff_src  = csalui[2:0];
    eff_func = csalui[5:3];
    eff_dst  = csalui[8:6];
    if (csalum == alu_contr_pkg::MODE_GPR_SRC) eff_src[1] = data.gpr0;
    if (csalum == alu_contr_pkg::MODE_GPR_FUNC) eff_func[0] = data.gpr0;
    if (csalum == alu_contr_pkg::MODE_MIC) eff_dst[2:1] = {~lcz_n, ~up_n};
  end

  // Operand and function strobe tables
  always_comb begin
    exp_strb.ra    = (eff_src[2:1] == 2'b00);
    exp_strb.rd    = eff_src inside {3'd5, 3'd6, 3'd7};
    exp_strb.sa    = eff_src inside {3'd4, 3'd5};
    exp_strb.sb    = eff_src inside {3'd1, 3'd3};
    exp_strb.rsn   = (eff_func == 3'd1);
    exp_strb.fsel  = eff_func inside {3'd2, 3'd5};
    exp_strb.log   = (eff_func >= 3'd3);
    exp_strb.alui4 = csalui[4];
  end

  always_ff @(posedge aluclk or negedge arst_n) begin
    if (!arst_n) begin
      cd_ref <= '0;
    end else if (ld_irv) begin
      cd_ref <= cd_10_9;
    end
  end

  assign low_fq   = state.dst_i6 ? data.f0 : data.q0;
  assign rri_opts = {data.sts7, data.cry & ~state.dst_i6, low_fq, data.f15};
  assign qli_opts = {data.sts7, 1'b0, data.f15, 1'b0};
  assign ci_opts  = {data.gpr0, data.sts6, 1'b1, 1'b0};

  a_reset: assert property (@(posedge aluclk)
    (!arst_n || !$past(arst_n)) |-> (strobes == '0 && !bdest && !ci))
    else note_failure("strobes, bdest or ci active in or right after reset");

  a_strobes: assert property (@(posedge aluclk) disable iff (!arst_n)
    $past(arst_n) |-> strobes == $past(exp_strb))
    else note_failure("operand or function strobes differ from the decode tables");

  a_state: assert property (@(posedge aluclk) disable iff (!arst_n)
    $past(arst_n) |-> ({state.dst_i8, state.dst_i7, state.dst_i6} == $past(eff_dst) &&
      state.sts_sel == $past(cssst) && state.cin_sel == $past(cscinsel) &&
      state.mic_mode == $past(csalum == alu_contr_pkg::MODE_MIC)))
    else note_failure("registered destination or select bits are wrong");

  a_shift_sel: assert property (@(posedge aluclk) disable iff (!arst_n)
    $past(arst_n) |-> state.shift_sel ==
      (($past(csalum) == alu_contr_pkg::MODE_MIC) ? $past(cd_ref) : $past(csmis)))
    else note_failure("shift select does not follow csmis or the CPU-data latch");

  a_bdest: assert property (@(posedge aluclk) disable iff (!arst_n)
    $past(arst_n) |-> bdest == $past(eff_dst[1] | eff_dst[2]))
    else note_failure("bdest does not follow destination bits 7 and 8");

  a_shift_link: assert property (@(posedge aluclk) disable iff (!arst_n)
    rri == rri_opts[state.shift_sel] && qli == qli_opts[state.shift_sel] &&
    rli == (state.dst_i6 ? qli_opts[state.shift_sel] : data.q15) &&
    mi == (state.dst_i7 ? data.f15 : low_fq))
    else note_failure("shift linkage outputs are wrong");

  // Q select is idle whenever destination bit 6 is set
  a_qsel: assert property (@(posedge aluclk) disable iff (!arst_n)
    qsel == (state.dst_i6 ? 2'b00 : {state.dst_i8, ~state.dst_i7}) &&
    alud2_n == ({state.dst_i8, state.dst_i7, state.dst_i6} != 3'b010))
    else note_failure("qsel or alud2_n decode is wrong");

  a_carry: assert property (@(posedge aluclk) disable iff (!arst_n)
    ci == ci_opts[state.cin_sel] &&
    gprli == ($countones({data.sts7, data.cry, data.gpr0}) >= 2))
    else note_failure("carry-in or GPR load-in majority is wrong");

  // Write code split by whether a load or extended fetch is active
  a_codes: assert property (@(posedge aluclk) disable iff (!arst_n)
    csts == (state.sts_sel | {state.mic_mode & state.dst_i8, 1'b0}) &&
    gprc == ((xfetch_n && ldgpr_n) ? {~state.dst_i8, 1'b1, state.dst_i7} :
                                     {2'b00, ldgpr_n & ~xfetch_n}))
    else note_failure("status-load code or GPR write code is wrong");

endmodule

bind alu_contr alu_contr_assert u_assert (.*);

//--- source/alu_contr.sv
// ALU controller top level
// Instruction stage, shift linkage and carry/status blocks

`timescale 1ns/1ps
`include "alu_contr_params.svh"

module alu_contr (
  input  logic                        aluclk,
  input  logic                        arst_n,
  input  logic [`ALU_INSTR_W-1:0]     csalui,
  input  logic [`ALU_MODE_W-1:0]      csalum,
  input  logic [`ALU_SEL_W-1:0]       csmis,
  input  logic [`ALU_SEL_W-1:0]       cssst,
  input  logic [`ALU_SEL_W-1:0]       cscinsel,
  input  logic [`ALU_SEL_W-1:0]       cd_10_9,
  input  logic                        ld_irv,
  input  alu_contr_pkg::alu_data_t    data,
  input  logic                        up_n,
  input  logic                        lcz_n,
  input  logic                        ldgpr_n,
  input  logic                        xfetch_n,
  output alu_contr_pkg::alu_strobe_t  strobes,
  output logic                        mi,
  output logic                        rri,
  output logic                        qli,
  output logic                        rli,
  output logic [1:0]                  qsel,
  output logic                        alud2_n,
  output logic                        bdest,
  output logic                        ci,
  output logic                        gprli,
  output logic [`ALU_SEL_W-1:0]       csts,
  output logic [`GPRC_W-1:0]          gprc
);

  alu_contr_pkg::alu_state_t state;  // Registered control state

  alu_instr_stage u_instr_stage (
    .aluclk   (aluclk),
    .arst_n   (arst_n),
    .csalui   (csalui),
    .csalum   (csalum),
    .csmis    (csmis),
    .cssst    (cssst),
    .cscinsel (cscinsel),
    .cd_10_9  (cd_10_9),
    .ld_irv   (ld_irv),
    .up_n     (up_n),
    .lcz_n    (lcz_n),
    .data     (data),
    .state    (state),
    .strobes  (strobes)
  );

  alu_shift_link u_shift_link (
    .state   (state),
    .data    (data),
    .mi      (mi),
    .rri     (rri),
    .qli     (qli),
    .rli     (rli),
    .qsel    (qsel),
    .alud2_n (alud2_n)
  );

  alu_carry_status u_carry_status (
    .state    (state),
    .data     (data),
    .ldgpr_n  (ldgpr_n),
    .xfetch_n (xfetch_n),
    .ci       (ci),
    .gprli    (gprli),
    .csts     (csts),
    .gprc     (gprc)
  );

  assign bdest = state.bdest;

endmodule

//--- source/alu_carry_status.sv
// Carry-in select, GPR load-in majority,
// status-load code and GPR write code

`timescale 1ns/1ps
`include "alu_contr_params.svh"

module alu_carry_status (
  input  alu_contr_pkg::alu_state_t state,
  input  alu_contr_pkg::alu_data_t  data,
  input  logic                      ldgpr_n,
  input  logic                      xfetch_n,
  output logic                      ci,
  output logic                      gprli,
  output logic [`ALU_SEL_W-1:0]     csts,
  output logic [`GPRC_W-1:0]        gprc
);

  logic gpr_idle;  // Neither load nor extended fetch

  // Carry in from constant, carry flag or GPR0
  always_comb begin
    case (state.cin_sel)
      2'd0:    ci = 1'b0;
      2'd1:    ci = 1'b1;
      2'd2:    ci = data.sts6;
      default: ci = data.gpr0;
    endcase
  end

  // Two of three
  assign gprli = (data.sts7 & data.cry) |
                 (data.sts7 & data.gpr0) |
                 (data.cry & data.gpr0);

  assign csts[0] = state.sts_sel[0];
  assign csts[1] = state.sts_sel[1] | (state.mic_mode & state.dst_i8);  // Load STS in MIC

  assign gpr_idle = xfetch_n & ldgpr_n;

  assign gprc[0] = ldgpr_n & ~(xfetch_n & ~state.dst_i7);
  assign gprc[1] = gpr_idle;
  assign gprc[2] = gpr_idle & ~state.dst_i8;

endmodule

//--- source/alu_shift_link.sv
// Shift linkage of the ALU slices
// RRI, QLI, RLI and MI multiplexers, Q select and ALU data 2 decode

`timescale 1ns/1ps

module alu_shift_link (
  input  alu_contr_pkg::alu_state_t state,
  input  alu_contr_pkg::alu_data_t  data,
  output logic                      mi,
  output logic                      rri,
  output logic                      qli,
  output logic                      rli,
  output logic [1:0]                qsel,
  output logic                      alud2_n
);

  logic f_or_q0;  // Low end of F or Q, picked by destination bit 6

  assign f_or_q0 = state.dst_i6 ? data.f0 : data.q0;

  // Right shift input and Q left input by shift select
  always_comb begin
    case (state.shift_sel)
      2'd0: begin
        rri = data.f15;
        qli = 1'b0;
      end
      2'd1: begin
        rri = f_or_q0;  // Rotate
        qli = data.f15;
      end
      2'd2: begin
        rri = data.cry & ~state.dst_i6;
        qli = 1'b0;
      end
      default: begin
        rri = data.sts7;  // Multishift link
        qli = data.sts7;
      end
    endcase
  end

  assign rli = state.dst_i6 ? qli : data.q15;
  assign mi  = state.dst_i7 ? data.f15 : f_or_q0;

  assign qsel[1] = ~state.dst_i6 & state.dst_i8;
  assign qsel[0] = ~state.dst_i6 & ~state.dst_i7;

  // Active low for destination pattern i8..i6 = 010
  assign alud2_n = ~(~state.dst_i6 & state.dst_i7 & ~state.dst_i8);

endmodule

//--- source/alu_instr_stage.sv
// ALU instruction stage
// Mode substitution of instruction bits, CPU-data latch,
// source and function decode, and the ALU-clock control registers

`timescale 1ns/1ps
`include "alu_contr_params.svh"

module alu_instr_stage (
  input  logic                           aluclk,
  input  logic                           arst_n,
  input  logic [`ALU_INSTR_W-1:0]        csalui,    // ALU instruction
  input  logic [`ALU_MODE_W-1:0]         csalum,    // ALU mode
  input  logic [`ALU_SEL_W-1:0]          csmis,     // Shift select
  input  logic [`ALU_SEL_W-1:0]          cssst,     // Status-set select
  input  logic [`ALU_SEL_W-1:0]          cscinsel,  // Carry-in select
  input  logic [`ALU_SEL_W-1:0]          cd_10_9,   // CPU data bits 10:9
  input  logic                           ld_irv,    // Load enable for the CPU-data latch
  input  logic                           up_n,
  input  logic                           lcz_n,
  input  alu_contr_pkg::alu_data_t       data,
  output alu_contr_pkg::alu_state_t      state,
  output alu_contr_pkg::alu_strobe_t     strobes
);

  alu_contr_pkg::alu_mode_e    mode;
  alu_contr_pkg::alu_src_e     src;
  alu_contr_pkg::alu_func_e    func;
  logic [`ALU_INSTR_W-1:0]     instr_eff;
  logic [`ALU_SEL_W-1:0]       cd_latch;
  alu_contr_pkg::alu_state_t   state_nxt;
  alu_contr_pkg::alu_strobe_t  strobes_nxt;

  assign mode = alu_contr_pkg::alu_mode_e'(csalum);

  // Replace instruction bits according to the live mode
  always_comb begin
    instr_eff = csalui;
    case (mode)
      alu_contr_pkg::MODE_GPR_SRC:  instr_eff[`ALU_SRC_LSB+1] = data.gpr0;
      alu_contr_pkg::MODE_GPR_FUNC: instr_eff[`ALU_FUNC_LSB]  = data.gpr0;
      alu_contr_pkg::MODE_MIC: begin
        instr_eff[`ALU_DST_LSB+1] = ~up_n;   // Up flag
        instr_eff[`ALU_DST_LSB+2] = ~lcz_n;  // Loop counter flag
      end
      default: ;
    endcase
  end

  assign src  = alu_contr_pkg::alu_src_e'(instr_eff[`ALU_SRC_LSB +: `ALU_FIELD_W]);
  assign func = alu_contr_pkg::alu_func_e'(instr_eff[`ALU_FUNC_LSB +: `ALU_FIELD_W]);

  // Operand and function strobes
  always_comb begin
    strobes_nxt = '0;
    case (src)
      alu_contr_pkg::SRC_AQ: strobes_nxt.ra = 1'b1;
      alu_contr_pkg::SRC_AB: begin
        strobes_nxt.ra = 1'b1;
        strobes_nxt.sb = 1'b1;
      end
      alu_contr_pkg::SRC_ZB: strobes_nxt.sb = 1'b1;
      alu_contr_pkg::SRC_ZA: strobes_nxt.sa = 1'b1;
      alu_contr_pkg::SRC_DA: begin
        strobes_nxt.rd = 1'b1;
        strobes_nxt.sa = 1'b1;
      end
      alu_contr_pkg::SRC_DQ,
      alu_contr_pkg::SRC_DZ: strobes_nxt.rd = 1'b1;
      default: ;  // ZQ drives no operand strobe
    endcase

    case (func)
      alu_contr_pkg::FUNC_SUBR: strobes_nxt.rsn = 1'b1;
      alu_contr_pkg::FUNC_SUBS: strobes_nxt.fsel = 1'b1;
      alu_contr_pkg::FUNC_NOTRS: begin
        strobes_nxt.fsel = 1'b1;
        strobes_nxt.log  = 1'b1;
      end
      alu_contr_pkg::FUNC_OR,
      alu_contr_pkg::FUNC_AND,
      alu_contr_pkg::FUNC_EXOR,
      alu_contr_pkg::FUNC_EXNOR: strobes_nxt.log = 1'b1;
      default: ;
    endcase
    strobes_nxt.alui4 = instr_eff[`ALU_FUNC_LSB+1];
  end

  // Next control state
  always_comb begin
    state_nxt.dst_i6    = instr_eff[`ALU_DST_LSB];
    state_nxt.dst_i7    = instr_eff[`ALU_DST_LSB+1];
    state_nxt.dst_i8    = instr_eff[`ALU_DST_LSB+2];
    state_nxt.mic_mode  = (mode == alu_contr_pkg::MODE_MIC);
    state_nxt.shift_sel = state_nxt.mic_mode ? cd_latch : csmis;  // IR bits in MIC mode
    state_nxt.sts_sel   = cssst;
    state_nxt.cin_sel   = cscinsel;
    state_nxt.bdest     = instr_eff[`ALU_DST_LSB+1] | instr_eff[`ALU_DST_LSB+2];
  end

  // CPU data latched from the instruction register
  always_ff @(posedge aluclk or negedge arst_n) begin
    if (!arst_n) begin
      cd_latch <= '0;
    end else if (ld_irv) begin
      cd_latch <= cd_10_9;
    end
  end

  always_ff @(posedge aluclk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= '0;
      strobes <= '0;
    end else begin
      state   <= state_nxt;
      strobes <= strobes_nxt;
    end
  end

endmodule

//--- source/alu_contr_pkg.sv
// Shared types for the ALU controller
// Enums for the ALU mode, source pair and function fields
// Packed structs for the registered state, the strobes and the datapath bits

`include "alu_contr_params.svh"

package alu_contr_pkg;

  typedef enum logic [`ALU_MODE_W-1:0] {
    MODE_NORMAL   = 2'd0,
    MODE_GPR_SRC  = 2'd1,  // Source bit 1 taken from GPR0
    MODE_GPR_FUNC = 2'd2,  // Function bit 3 taken from GPR0
    MODE_MIC      = 2'd3   // Shift and destination from IR and flags
  } alu_mode_e;

  // R and S operand pairs of the bit-slice ALU
  typedef enum logic [`ALU_FIELD_W-1:0] {
    SRC_AQ = 3'd0,
    SRC_AB = 3'd1,
    SRC_ZQ = 3'd2,
    SRC_ZB = 3'd3,
    SRC_ZA = 3'd4,
    SRC_DA = 3'd5,
    SRC_DQ = 3'd6,
    SRC_DZ = 3'd7
  } alu_src_e;

  typedef enum logic [`ALU_FIELD_W-1:0] {
    FUNC_ADD   = 3'd0,
    FUNC_SUBR  = 3'd1,
    FUNC_SUBS  = 3'd2,
    FUNC_OR    = 3'd3,
    FUNC_AND   = 3'd4,
    FUNC_NOTRS = 3'd5,
    FUNC_EXOR  = 3'd6,
    FUNC_EXNOR = 3'd7
  } alu_func_e;

  typedef struct packed {
    logic                  dst_i6;
    logic                  dst_i7;
    logic                  dst_i8;
    logic [`ALU_SEL_W-1:0] shift_sel;
    logic [`ALU_SEL_W-1:0] sts_sel;
    logic [`ALU_SEL_W-1:0] cin_sel;
    logic                  bdest;
    logic                  mic_mode;   // Mode was MIC when registered
  } alu_state_t;

  typedef struct packed {
    logic ra;
    logic rd;
    logic sa;
    logic sb;
    logic rsn;
    logic fsel;
    logic log;
    logic alui4;
  } alu_strobe_t;

  typedef struct packed {
    logic f0;
    logic f15;
    logic q0;
    logic q15;
    logic cry;
    logic gpr0;
    logic sts6;    // Carry flag
    logic sts7;    // Multishift flag
  } alu_data_t;

endpackage

//--- source/alu_contr_params.svh
// Field widths and bit positions of the microcoded ALU instruction
// Widths of the mode, the 2-bit selects and the GPR write code

`ifndef ALU_CONTR_PARAMS_SVH
`define ALU_CONTR_PARAMS_SVH

// Instruction word and its three 3-bit fields
`define ALU_INSTR_W   9
`define ALU_FIELD_W   3
`define ALU_SRC_LSB   0   // Source operand pair
`define ALU_FUNC_LSB  3   // ALU function
`define ALU_DST_LSB   6   // Destination and shift

// ALU mode from the control store
`define ALU_MODE_W    2

// Shift, status, carry-in and CPU-data selects
`define ALU_SEL_W     2

// GPR write code
`define GPRC_W        3

`endif
